// File: Bender.yml
package:
  name: mgmt_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/mgmt_pkg.sv
      - design/fan_tach.sv
      - regs/mgmt_regs.sv
      - spi/frontpanel_spi_host.sv
      - design/mgmt_subsystem.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/mgmt_props.sv
      - sim/tb_mgmt_subsystem.sv

// File: common/mgmt_defines.svh
`ifndef MGMT_DEFINES_SVH
`define MGMT_DEFINES_SVH

// Number of crossbar channels, also the LED vector width
`define MGMT_NUM_TRIG 12

// Tachometer gate window in sys_clk cycles
`define MGMT_TACH_WINDOW 2000
// RPM per tach edge counted in one window
`define MGMT_TACH_RPM_MULT 30

// sys_clk cycles per SCK half period
`define MGMT_SPI_CLKDIV 4

// Cycles from read strobe to read valid
`define MGMT_RD_LATENCY 2

// Register map
`define MGMT_REG_SCRATCH 16'h0000
`define MGMT_REG_FAN0_LO 16'h0010
`define MGMT_REG_FAN0_HI 16'h0011
`define MGMT_REG_FAN1_LO 16'h0012
`define MGMT_REG_FAN1_HI 16'h0013
`define MGMT_REG_FP_DATA 16'h0030
`define MGMT_REG_FP_CS 16'h0031
`define MGMT_REG_FP_STATUS 16'h0032
// Twelve consecutive mux-select bytes start here
`define MGMT_REG_MUXSEL_BASE 16'h0040
`define MGMT_REG_LED_IN_LO 16'h0050
`define MGMT_REG_LED_IN_HI 16'h0051
`define MGMT_REG_LED_OUT_LO 16'h0052
`define MGMT_REG_LED_OUT_HI 16'h0053

`endif

// File: common/mgmt_pkg.sv
package mgmt_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host register bus

	// Byte address of one management register
	typedef logic [15:0] mgmt_addr_t;

	// One register byte, both write data and read data
	typedef logic [7:0] mgmt_data_t;

	//////////////////////////////////////////////////////////////////////
	// Fan and crossbar types

	// Fan speed in revolutions per minute
	typedef logic [15:0] rpm_t;

	// Trigger input index that feeds one crossbar output
	// Only 12 inputs exist, codes above 11 select nothing useful
	typedef logic [3:0] muxsel_t;

endpackage

// File: design/fan_tach.sv
`timescale 1ns/10ps

module fan_tach #(
	parameter int WINDOW_CYCLES = 2000,
	parameter int RPM_MULT      = 30
) (
	input  logic          sys_clk,
	input  logic          arst_n,
	input  logic          tach,
	output mgmt_pkg::rpm_t rpm
);

	import mgmt_pkg::*;

	// Window counter width
	localparam int CNT_W = $clog2(WINDOW_CYCLES);

	//////////////////////////////////////////////////////////////////////
	// Pin synchronizer and edge detect

	logic [1:0] tach_sync;
	logic       tach_prev;
	logic       tach_rise;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			tach_sync <= 2'b00;
			tach_prev <= 1'b0;
		end else begin
			// Two flops against metastability, third for the edge
			tach_sync <= {tach_sync[0], tach};
			tach_prev <= tach_sync[1];
		end
	end

	assign tach_rise = tach_sync[1] & ~tach_prev;

	//////////////////////////////////////////////////////////////////////
	// Gate window and edge count

	logic [CNT_W-1:0] window_cnt;
	logic             window_end;
	rpm_t             edge_cnt;

	assign window_end = (window_cnt == CNT_W'(WINDOW_CYCLES - 1));

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			window_cnt <= '0;
			edge_cnt   <= '0;
			rpm        <= '0;
		end else begin
			if (window_end) begin
				window_cnt <= '0;
				// Scale the finished count
				rpm <= rpm_t'(edge_cnt * RPM_MULT);
				// An edge on the last cycle opens the next window
				edge_cnt <= rpm_t'(tach_rise);
			end else begin
				window_cnt <= window_cnt + 1'b1;
				if (tach_rise)
					edge_cnt <= edge_cnt + 1'b1;
			end
		end
	end

endmodule

// File: design/mgmt_subsystem.sv
`timescale 1ns/10ps
`include "mgmt_defines.svh"

module mgmt_subsystem (
	input  logic                                            sys_clk,
	input  logic                                            arst_n,

	// Host register bus
	input  logic                                            wr_en,
	input  mgmt_pkg::mgmt_addr_t                            wr_addr,
	input  mgmt_pkg::mgmt_data_t                            wr_data,
	input  logic                                            rd_en,
	input  mgmt_pkg::mgmt_addr_t                            rd_addr,
	output logic                                            rd_valid,
	output mgmt_pkg::mgmt_data_t                            rd_data,

	// Fan tachometer pins
	input  logic [1:0]                                      fan_tach,

	// Front panel SPI
	output logic                                            frontpanel_sck,
	output logic                                            frontpanel_mosi,
	input  logic                                            frontpanel_miso,
	output logic                                            frontpanel_cs_n,

	// Crossbar status and control
	input  logic [`MGMT_NUM_TRIG-1:0]                       trig_in_led,
	input  logic [`MGMT_NUM_TRIG-1:0]                       trig_out_led,
	output mgmt_pkg::muxsel_t [`MGMT_NUM_TRIG-1:0]          muxsel
);

	import mgmt_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Fan tachometers

	rpm_t fan0_rpm;
	rpm_t fan1_rpm;

	fan_tach #(
		.WINDOW_CYCLES(`MGMT_TACH_WINDOW),
		.RPM_MULT(`MGMT_TACH_RPM_MULT)
	) tach0_inst (
		.sys_clk(sys_clk),
		.arst_n(arst_n),
		.tach(fan_tach[0]),
		.rpm(fan0_rpm)
	);

	fan_tach #(
		.WINDOW_CYCLES(`MGMT_TACH_WINDOW),
		.RPM_MULT(`MGMT_TACH_RPM_MULT)
	) tach1_inst (
		.sys_clk(sys_clk),
		.arst_n(arst_n),
		.tach(fan_tach[1]),
		.rpm(fan1_rpm)
	);

	//////////////////////////////////////////////////////////////////////
	// Front panel SPI host

	logic       shift_en;
	mgmt_data_t front_tx_data;
	logic       shift_done;
	mgmt_data_t front_rx_data;

	frontpanel_spi_host #(
		.CLKDIV(`MGMT_SPI_CLKDIV)
	) spi_inst (
		.sys_clk(sys_clk),
		.arst_n(arst_n),
		.shift_en(shift_en),
		.tx_data(front_tx_data),
		.spi_miso(frontpanel_miso),
		.shift_done(shift_done),
		.rx_data(front_rx_data),
		.spi_sck(frontpanel_sck),
		.spi_mosi(frontpanel_mosi)
	);

	//////////////////////////////////////////////////////////////////////
	// Register block

	mgmt_regs regs_inst (
		.sys_clk(sys_clk),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.fan0_rpm(fan0_rpm),
		.fan1_rpm(fan1_rpm),
		.shift_done(shift_done),
		.front_rx_data(front_rx_data),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.shift_en(shift_en),
		.front_tx_data(front_tx_data),
		.front_cs_n(frontpanel_cs_n),
		.muxsel(muxsel)
	);

endmodule

// File: files.f
+incdir+common
common/mgmt_pkg.sv
design/fan_tach.sv
regs/mgmt_regs.sv
spi/frontpanel_spi_host.sv
design/mgmt_subsystem.sv
sim/mgmt_props.sv
sim/tb_mgmt_subsystem.sv

// File: regs/mgmt_regs.sv
`timescale 1ns/10ps
`include "mgmt_defines.svh"

module mgmt_regs (
	input  logic                                            sys_clk,
	input  logic                                            arst_n,

	// Host bus, before the pipeline stage
	input  logic                                            wr_en,
	input  mgmt_pkg::mgmt_addr_t                            wr_addr,
	input  mgmt_pkg::mgmt_data_t                            wr_data,
	input  logic                                            rd_en,
	input  mgmt_pkg::mgmt_addr_t                            rd_addr,

	// Status inputs
	input  mgmt_pkg::rpm_t                                  fan0_rpm,
	input  mgmt_pkg::rpm_t                                  fan1_rpm,
	input  logic                                            shift_done,
	input  mgmt_pkg::mgmt_data_t                            front_rx_data,
	input  logic [`MGMT_NUM_TRIG-1:0]                       trig_in_led,
	input  logic [`MGMT_NUM_TRIG-1:0]                       trig_out_led,

	// Read response
	output logic                                            rd_valid,
	output mgmt_pkg::mgmt_data_t                            rd_data,

	// Control outputs
	output logic                                            shift_en,
	output mgmt_pkg::mgmt_data_t                            front_tx_data,
	output logic                                            front_cs_n,
	output mgmt_pkg::muxsel_t [`MGMT_NUM_TRIG-1:0]          muxsel
);

	import mgmt_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Input pipeline stage

	logic       wr_en_ff;
	mgmt_addr_t wr_addr_ff;
	mgmt_data_t wr_data_ff;
	logic       rd_en_ff;
	mgmt_addr_t rd_addr_ff;

	// Strobes
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_en_ff <= 1'b0;
			rd_en_ff <= 1'b0;
		end else begin
			wr_en_ff <= wr_en;
			rd_en_ff <= rd_en;
		end
	end

	// Address and data
	always_ff @(posedge sys_clk) begin
		wr_addr_ff <= wr_addr;
		wr_data_ff <= wr_data;
		rd_addr_ff <= rd_addr;
	end

	//////////////////////////////////////////////////////////////////////
	// Write decode and SPI launch

	mgmt_data_t scratch;
	logic       fp_busy;
	mgmt_data_t fp_rx_byte;

	// Launch only when the shifter is idle, a busy write is dropped
	assign shift_en      = wr_en_ff && (wr_addr_ff == `MGMT_REG_FP_DATA) && !fp_busy;
	assign front_tx_data = wr_data_ff;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			scratch    <= '0;
			front_cs_n <= 1'b1;
			muxsel     <= '0;
		end else if (wr_en_ff) begin
			case (wr_addr_ff)
				`MGMT_REG_SCRATCH: scratch <= wr_data_ff;
				`MGMT_REG_FP_CS:   front_cs_n <= wr_data_ff[0];
				default: ;
			endcase
			// One byte per crossbar output
			for (int i = 0; i < `MGMT_NUM_TRIG; i++) begin
				if (wr_addr_ff == mgmt_addr_t'(`MGMT_REG_MUXSEL_BASE + i))
					muxsel[i] <= wr_data_ff[3:0];
			end
		end
	end

	// Busy flag and received byte
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			fp_busy    <= 1'b0;
			fp_rx_byte <= '0;
		end else begin
			if (shift_en)
				fp_busy <= 1'b1;
			else if (shift_done)
				fp_busy <= 1'b0;
			if (shift_done)
				fp_rx_byte <= front_rx_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read mux and RPM snapshot

	mgmt_data_t rd_mux;
	mgmt_data_t fan0_hi_snap;
	mgmt_data_t fan1_hi_snap;

	always_comb begin
		case (rd_addr_ff)
			`MGMT_REG_SCRATCH:    rd_mux = scratch;
			`MGMT_REG_FAN0_LO:    rd_mux = fan0_rpm[7:0];
			`MGMT_REG_FAN0_HI:    rd_mux = fan0_hi_snap;
			`MGMT_REG_FAN1_LO:    rd_mux = fan1_rpm[7:0];
			`MGMT_REG_FAN1_HI:    rd_mux = fan1_hi_snap;
			`MGMT_REG_FP_DATA:    rd_mux = fp_rx_byte;
			`MGMT_REG_FP_CS:      rd_mux = {7'b0, front_cs_n};
			`MGMT_REG_FP_STATUS:  rd_mux = {7'b0, fp_busy};
			// High bytes land in the low nibble
			`MGMT_REG_LED_IN_LO:  rd_mux = trig_in_led[7:0];
			`MGMT_REG_LED_IN_HI:  rd_mux = mgmt_data_t'(trig_in_led >> 8);
			`MGMT_REG_LED_OUT_LO: rd_mux = trig_out_led[7:0];
			`MGMT_REG_LED_OUT_HI: rd_mux = mgmt_data_t'(trig_out_led >> 8);
			default:              rd_mux = '0;
		endcase
		for (int i = 0; i < `MGMT_NUM_TRIG; i++) begin
			if (rd_addr_ff == mgmt_addr_t'(`MGMT_REG_MUXSEL_BASE + i))
				rd_mux = {4'h0, muxsel[i]};
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid     <= 1'b0;
			rd_data      <= '0;
			fan0_hi_snap <= '0;
			fan1_hi_snap <= '0;
		end else begin
			rd_valid <= rd_en_ff;
			if (rd_en_ff) begin
				rd_data <= rd_mux;
				// Low byte read freezes the matching high byte
				if (rd_addr_ff == `MGMT_REG_FAN0_LO)
					fan0_hi_snap <= fan0_rpm[15:8];
				if (rd_addr_ff == `MGMT_REG_FAN1_LO)
					fan1_hi_snap <= fan1_rpm[15:8];
			end
		end
	end

endmodule

// File: sim/mgmt_props.sv
`timescale 1ns/10ps

module mgmt_props (
	input logic sys_clk,
	input logic arst_n,
	input logic rd_en,
	input logic rd_valid,
	input logic frontpanel_sck,
	input logic frontpanel_cs_n
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	// Each read strobe gets its valid two cycles later
	rd_latency: assert property (@(posedge sys_clk) disable iff (!arst_n)
		rd_en |-> ##2 rd_valid)
		else begin
			$error("rd_valid missing two cycles after rd_en");
			fail_count++;
		end

	// and no valid comes without such a strobe
	rd_no_orphan: assert property (@(posedge sys_clk) disable iff (!arst_n)
		rd_valid |-> $past(rd_en, 2))
		else begin
			$error("rd_valid without rd_en two cycles earlier");
			fail_count++;
		end

	// Chip select only rises with SCK idle low
	cs_sck_idle: assert property (@(posedge sys_clk) disable iff (!arst_n)
		$rose(frontpanel_cs_n) |-> !frontpanel_sck)
		else begin
			$error("frontpanel_sck high as frontpanel_cs_n rose");
			fail_count++;
		end

	// Quiet bus right out of reset
	reset_quiet: assert property (@(posedge sys_clk)
		$rose(arst_n) |-> !rd_valid ##1 !rd_valid)
		else begin
			$error("rd_valid asserted in the first cycle after reset");
			fail_count++;
		end

endmodule

bind mgmt_subsystem mgmt_props props_inst (.*);

// File: sim/mgmt_stim.txt
// One 40-bit word per entry: op[39:32] addr[31:16] b[15:8] c[7:0]
// 01 write b, 02 read expect b, 03 SPI send b device returns c, 04 fan addr=index b=period
// 05 LED check, 06 two reads expect b, 07 write b with read of old c, 08 mux sweep base b
0200000000 // Scratch after reset
010000A500
020000A500
060000A500 // Back to back
0700003CA5 // Same cycle write and read
0200003C00
080000F300 // All twelve mux selects
0800005A00
0200200000 // Unmapped addresses
0100207700
0200200000
02004C0000
02FFFF0000
0200310100 // Chip select idles high
0100310000
0200310000
0300009C5E // SPI bytes
0300003AC1
0200320000
0100310100
0200310100
0400006400 // Fan 0, 100 cycle period
0400015000 // Fan 1, 80 cycle period
0500000000 // Random LED inputs
0500000000
0000000000

// File: sim/tb_mgmt_subsystem.sv
`timescale 1ns/10ps
`include "mgmt_defines.svh"

module tb_mgmt_subsystem;

	import mgmt_pkg::*;

	// Stim opcodes as listed in the stim file header
	localparam logic [7:0] OP_END    = 8'h00;
	localparam logic [7:0] OP_WRITE  = 8'h01;
	localparam logic [7:0] OP_READ   = 8'h02;
	localparam logic [7:0] OP_SPI    = 8'h03;
	localparam logic [7:0] OP_FAN    = 8'h04;
	localparam logic [7:0] OP_LED    = 8'h05;
	localparam logic [7:0] OP_READ2  = 8'h06;
	localparam logic [7:0] OP_WR_RD  = 8'h07;
	localparam logic [7:0] OP_MUX    = 8'h08;
	localparam int         STIM_DEPTH = 64;
	// Status polls before giving up on the SPI busy bit
	localparam int         BUSY_POLLS = 100;

	logic                              sys_clk;
	logic                              arst_n;
	logic                              wr_en;
	mgmt_addr_t                        wr_addr;
	mgmt_data_t                        wr_data;
	logic                              rd_en;
	mgmt_addr_t                        rd_addr;
	logic                              rd_valid;
	mgmt_data_t                        rd_data;
	logic                              tach0;
	logic                              tach1;
	logic                              frontpanel_sck;
	logic                              frontpanel_mosi;
	logic                              frontpanel_miso;
	logic                              frontpanel_cs_n;
	logic [`MGMT_NUM_TRIG-1:0]         trig_in_led;
	logic [`MGMT_NUM_TRIG-1:0]         trig_out_led;
	muxsel_t [`MGMT_NUM_TRIG-1:0]      muxsel;

	integer      seed;
	int          errors;
	int          timeouts;
	int          assert_fails;
	int          ops;
	// Full tach period per fan in sys_clk cycles or 0 when stopped
	int          fan_period [2];
	logic [39:0] stim_mem [0:STIM_DEPTH-1];
	// SPI device model state
	mgmt_data_t  dev_shift;
	mgmt_data_t  mosi_cap;
	int          mosi_bits;

	mgmt_subsystem mgmt_subsystem_inst (
		.sys_clk(sys_clk),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.fan_tach({tach1, tach0}),
		.frontpanel_sck(frontpanel_sck),
		.frontpanel_mosi(frontpanel_mosi),
		.frontpanel_miso(frontpanel_miso),
		.frontpanel_cs_n(frontpanel_cs_n),
		.trig_in_led(trig_in_led),
		.trig_out_led(trig_out_led),
		.muxsel(muxsel)
	);

	always #20 sys_clk = ~sys_clk;

	//////////////////////////////////////////////////////////////////////
	// SPI device and fan models

	// Mode 0 device, MSB first
	assign frontpanel_miso = dev_shift[7];

	always @(posedge frontpanel_sck) begin
		mosi_cap  = {mosi_cap[6:0], frontpanel_mosi};
		mosi_bits = mosi_bits + 1;
	end

	// Next MISO bit shortly after SCK falls
	always @(negedge frontpanel_sck) begin
		#2;
		dev_shift = {dev_shift[6:0], 1'b0};
	end

	// Toggles land 7 ns off the clock grid and never on a rising edge
	always begin
		if (fan_period[0] == 0) begin
			@(posedge sys_clk);
			#7;
		end else begin
			#(fan_period[0] * 20);
			tach0 = ~tach0;
		end
	end

	always begin
		if (fan_period[1] == 0) begin
			@(posedge sys_clk);
			#7;
		end else begin
			#(fan_period[1] * 20);
			tach1 = ~tach1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus tasks and checks

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("ERROR %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
	endtask

	task automatic drive_write(input mgmt_addr_t addr, input mgmt_data_t data);
		@(posedge sys_clk);
		#2;
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(posedge sys_clk);
		#2;
		wr_en = 1'b0;
	endtask

	// Valid must show up exactly two cycles after the strobe
	task automatic read_reg(input mgmt_addr_t addr, output mgmt_data_t data);
		@(posedge sys_clk);
		#2;
		rd_en   = 1'b1;
		rd_addr = addr;
		@(posedge sys_clk);
		#2;
		rd_en = 1'b0;
		if (rd_valid !== 1'b0)
			report_mismatch("rd_valid", rd_valid, 0);
		@(posedge sys_clk);
		#2;
		if (rd_valid !== 1'b1)
			report_mismatch("rd_valid", rd_valid, 1);
		data = rd_data;
	endtask

	task automatic check_read(input mgmt_addr_t addr, input mgmt_data_t exp);
		mgmt_data_t got;
		read_reg(addr, got);
		if (got !== exp)
			report_mismatch($sformatf("rd_data @0x%04h", addr), got, exp);
	endtask

	// Output pins and fan speeds straight out of reset
	task automatic reset_state_check();
		if (rd_valid !== 1'b0)
			report_mismatch("rd_valid", rd_valid, 0);
		if (frontpanel_sck !== 1'b0)
			report_mismatch("frontpanel_sck", frontpanel_sck, 0);
		if (frontpanel_cs_n !== 1'b1)
			report_mismatch("frontpanel_cs_n", frontpanel_cs_n, 1);
		for (int i = 0; i < `MGMT_NUM_TRIG; i++) begin
			if (muxsel[i] !== 4'h0)
				report_mismatch($sformatf("muxsel[%0d]", i), muxsel[i], 0);
		end
		// Well inside the first window
		check_read(`MGMT_REG_FAN0_LO, 8'h00);
		check_read(`MGMT_REG_FAN1_LO, 8'h00);
	endtask

	// Two strobes on consecutive cycles
	task automatic read_twice(input mgmt_addr_t addr, input mgmt_data_t exp);
		@(posedge sys_clk);
		#2;
		rd_en   = 1'b1;
		rd_addr = addr;
		repeat (2) @(posedge sys_clk);
		#2;
		rd_en = 1'b0;
		for (int n = 0; n < 2; n++) begin
			if (rd_valid !== 1'b1)
				report_mismatch("rd_valid", rd_valid, 1);
			if (rd_data !== exp)
				report_mismatch("rd_data", rd_data, exp);
			@(posedge sys_clk);
			#2;
		end
	endtask

	// Read in the write cycle still sees the old value
	task automatic write_during_read(input mgmt_addr_t addr, input mgmt_data_t data,
		input mgmt_data_t old);
		@(posedge sys_clk);
		#2;
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		rd_en   = 1'b1;
		rd_addr = addr;
		@(posedge sys_clk);
		#2;
		wr_en = 1'b0;
		rd_en = 1'b0;
		@(posedge sys_clk);
		#2;
		if (rd_valid !== 1'b1)
			report_mismatch("rd_valid", rd_valid, 1);
		if (rd_data !== old)
			report_mismatch("rd_data", rd_data, old);
	endtask

	task automatic mux_sweep(input mgmt_data_t base);
		mgmt_data_t val [`MGMT_NUM_TRIG];
		for (int i = 0; i < `MGMT_NUM_TRIG; i++) begin
			// Upper nibble varies too and must be dropped
			val[i] = base + mgmt_data_t'(i * 8'h13);
			drive_write(mgmt_addr_t'(`MGMT_REG_MUXSEL_BASE + i), val[i]);
		end
		@(posedge sys_clk);
		#2;
		for (int i = 0; i < `MGMT_NUM_TRIG; i++) begin
			if (muxsel[i] !== val[i][3:0])
				report_mismatch($sformatf("muxsel[%0d]", i), muxsel[i], val[i][3:0]);
		end
		for (int i = 0; i < `MGMT_NUM_TRIG; i++)
			check_read(mgmt_addr_t'(`MGMT_REG_MUXSEL_BASE + i), {4'h0, val[i][3:0]});
	endtask

	task automatic spi_transfer(input mgmt_data_t tx, input mgmt_data_t rx);
		mgmt_data_t status;
		int         polls;
		dev_shift = rx;
		mosi_bits = 0;
		drive_write(`MGMT_REG_FP_DATA, tx);
		if (frontpanel_cs_n !== 1'b0)
			report_mismatch("frontpanel_cs_n", frontpanel_cs_n, 0);
		// Poll busy until the byte is done
		status = 8'h01;
		polls  = 0;
		while (status[0] !== 1'b0 && polls < BUSY_POLLS) begin
			read_reg(`MGMT_REG_FP_STATUS, status);
			polls++;
		end
		if (status[0] !== 1'b0) begin
			timeouts++;
			$display("Timeout: SPI busy bit did not clear after %0d polls", polls);
		end
		if (mosi_bits != 8)
			report_mismatch("sck rising edges", mosi_bits, 8);
		if (mosi_cap !== tx)
			report_mismatch("frontpanel_mosi byte", mosi_cap, tx);
		check_read(`MGMT_REG_FP_DATA, rx);
	endtask

	task automatic fan_check(input int idx, input int period);
		mgmt_data_t lo;
		mgmt_data_t hi;
		rpm_t       got;
		int         edges;
		fan_period[idx] = period;
		// Two windows, so the last one saw only the new period
		repeat (2 * `MGMT_TACH_WINDOW + 16) @(posedge sys_clk);
		read_reg(mgmt_addr_t'(`MGMT_REG_FAN0_LO + 2 * idx), lo);
		read_reg(mgmt_addr_t'(`MGMT_REG_FAN0_HI + 2 * idx), hi);
		got   = {hi, lo};
		edges = `MGMT_TACH_WINDOW / period;
		// Free window phase allows one edge either way
		if (got < (edges - 1) * `MGMT_TACH_RPM_MULT || got > (edges + 1) * `MGMT_TACH_RPM_MULT)
			report_mismatch($sformatf("fan%0d rpm (+/-1 edge)", idx), got,
				edges * `MGMT_TACH_RPM_MULT);
	endtask

	task automatic led_check();
		@(posedge sys_clk);
		#2;
		trig_in_led  = $random(seed);
		trig_out_led = $random(seed);
		check_read(`MGMT_REG_LED_IN_LO, trig_in_led[7:0]);
		check_read(`MGMT_REG_LED_IN_HI, {4'h0, trig_in_led[11:8]});
		check_read(`MGMT_REG_LED_OUT_LO, trig_out_led[7:0]);
		check_read(`MGMT_REG_LED_OUT_HI, {4'h0, trig_out_led[11:8]});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		logic [39:0] op;
		int          idx;
		seed          = 74247;
		sys_clk       = 1'b0;
		arst_n        = 1'b0;
		wr_en         = 1'b0;
		wr_addr       = '0;
		wr_data       = '0;
		rd_en         = 1'b0;
		rd_addr       = '0;
		tach0         = 1'b0;
		tach1         = 1'b0;
		dev_shift     = '0;
		mosi_cap      = '0;
		mosi_bits     = 0;
		errors        = 0;
		timeouts      = 0;
		assert_fails  = 0;
		ops           = 0;
		fan_period[0] = 0;
		fan_period[1] = 0;
		trig_in_led   = $random(seed);
		trig_out_led  = $random(seed);
		for (int i = 0; i < STIM_DEPTH; i++)
			stim_mem[i] = '0;
		$readmemh("sim/mgmt_stim.txt", stim_mem);

		repeat (16) @(posedge sys_clk);
		#2;
		arst_n = 1'b1;

		reset_state_check();

		idx = 0;
		while (idx < STIM_DEPTH && stim_mem[idx][39:32] !== OP_END) begin
			op = stim_mem[idx];
			case (op[39:32])
				OP_WRITE: drive_write(op[31:16], op[15:8]);
				OP_READ:  check_read(op[31:16], op[15:8]);
				OP_SPI:   spi_transfer(op[15:8], op[7:0]);
				OP_FAN:   fan_check(op[31:16], op[15:8]);
				OP_LED:   led_check();
				OP_READ2: read_twice(op[31:16], op[15:8]);
				OP_WR_RD: write_during_read(op[31:16], op[15:8], op[7:0]);
				OP_MUX:   mux_sweep(op[15:8]);
				default: begin
					errors++;
					$display("Unknown stim opcode 0x%02h in entry %0d", op[39:32], idx);
				end
			endcase
			ops++;
			idx++;
		end
		if (ops == 0) begin
			errors++;
			$display("No stimulus entries were read from sim/mgmt_stim.txt");
		end

		repeat (4) @(posedge sys_clk);
		assert_fails = mgmt_subsystem_inst.props_inst.fail_count;
		$display("ops %0d errors %0d timeouts %0d assertion failures %0d",
			ops, errors, timeouts, assert_fails);
		if (errors == 0 && timeouts == 0 && assert_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: spi/frontpanel_spi_host.sv
`timescale 1ns/10ps

module frontpanel_spi_host #(
	parameter int CLKDIV = 4
) (
	input  logic                 sys_clk,
	input  logic                 arst_n,

	// Byte interface
	input  logic                 shift_en,
	input  mgmt_pkg::mgmt_data_t tx_data,
	output logic                 shift_done,
	output mgmt_pkg::mgmt_data_t rx_data,

	// SPI pins, mode 0
	output logic                 spi_sck,
	output logic                 spi_mosi,
	input  logic                 spi_miso
);

	import mgmt_pkg::*;

	// Half period counter width
	localparam int DIV_W = $clog2(CLKDIV + 1);

	//////////////////////////////////////////////////////////////////////
	// Shifter state

	logic             active;
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	mgmt_data_t       tx_shift;
	mgmt_data_t       rx_shift;
	logic             half_end;

	assign half_end = (div_cnt == DIV_W'(CLKDIV - 1));

	// MSB first, MOSI changes only while SCK is low
	assign spi_mosi = tx_shift[7];
	assign rx_data  = rx_shift;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			active     <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			tx_shift   <= '0;
			rx_shift   <= '0;
			spi_sck    <= 1'b0;
			shift_done <= 1'b0;
		end else begin
			shift_done <= 1'b0;
			if (!active) begin
				// Start a byte
				if (shift_en) begin
					active   <= 1'b1;
					div_cnt  <= '0;
					bit_cnt  <= '0;
					tx_shift <= tx_data;
				end
			end else if (!half_end) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
				if (!spi_sck) begin
					// Rising edge, sample MISO
					spi_sck  <= 1'b1;
					rx_shift <= {rx_shift[6:0], spi_miso};
				end else begin
					// Falling edge, present next bit
					spi_sck  <= 1'b0;
					tx_shift <= {tx_shift[6:0], 1'b0};
					bit_cnt  <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) begin
						active     <= 1'b0;
						shift_done <= 1'b1;
					end
				end
			end
		end
	end

endmodule
